// ==== common/config_net_consts.svh ====
`ifndef CONFIG_NET_CONSTS_SVH
`define CONFIG_NET_CONSTS_SVH

// field widths of one serial packet
`define CONFIG_ID_BITS 8
`define CONFIG_DATA_BITS 16

// start bit + id + data + stop bit
`define CONFIG_PACKET_BITS (`CONFIG_ID_BITS + `CONFIG_DATA_BITS + 2)

// framing levels on the line
`define CONFIG_START_BIT 1'b0
`define CONFIG_STOP_BIT 1'b1
// line rests high between packets
`define CONFIG_IDLE_BIT 1'b1

// register stages between producer and nodes
`define CONFIG_RELAY_STAGES 2

// addresses of the two consumers
`define CONFIG_NODE0_ID 8'h05
`define CONFIG_NODE1_ID 8'h2a

// packet pushed out right after reset
`define CONFIG_RESET_ID `CONFIG_NODE0_ID
`define CONFIG_RESET_DATA 16'hbeef

`endif

// ==== common/config_net_pkg.sv ====
`include "config_net_consts.svh"

package config_net_pkg;

  // node address as carried in the id field
  typedef logic [`CONFIG_ID_BITS-1:0] config_id_t;

  // payload written into a node register
  typedef logic [`CONFIG_DATA_BITS-1:0] config_data_t;

  // full frame, bit 0 leaves first
  typedef logic [`CONFIG_PACKET_BITS-1:0] config_packet_t;

  // receiver phases of config_node
  typedef enum logic [1:0] {
    // waiting for a start bit
    node_idle = 2'd0,
    // collecting the id field
    node_id   = 2'd1,
    // collecting the data field
    node_data = 2'd2,
    // waiting for the line to go high again
    node_stop = 2'd3
  } node_state_t;

endpackage

// ==== config_net.f ====
+incdir+common
common/config_net_pkg.sv
src/config_vector.sv
src/config_relay.sv
config_node/config_node.sv
src/config_net_top.sv
test/config_net_tb.sv

// ==== config_node/config_node.sv ====
`timescale 1ns/1ns
`include "config_net_consts.svh"

module config_node #(
  parameter config_net_pkg::config_id_t node_id_p = `CONFIG_NODE0_ID
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         cfg_bit_i,
  output config_net_pkg::config_data_t data_o,
  output logic                         update_o
);

  // counts bits within the current field, data is the longer one
  localparam int cnt_w = $clog2(`CONFIG_DATA_BITS);

  config_net_pkg::node_state_t  state_r;
  logic [cnt_w-1:0]             cnt_r;
  // shared collector for id then data, filled from the top
  config_net_pkg::config_data_t shift_r;
  config_net_pkg::config_data_t shift_next;
  config_net_pkg::config_id_t   id_next;
  // set when the id field equals this node's address
  logic                         match_r;
  config_net_pkg::config_data_t data_r;
  logic                         update_r;

  // incoming bit lands at msb, so after a whole field it sits lsb-aligned
  assign shift_next = {cfg_bit_i, shift_r[`CONFIG_DATA_BITS-1:1]};

  // after the id field the id occupies the top bits of the collector
  assign id_next = shift_next[`CONFIG_DATA_BITS-1 -: `CONFIG_ID_BITS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= config_net_pkg::node_idle;
      cnt_r    <= '0;
      data_r   <= '0;
      update_r <= 1'b0;
    end else begin
      // update is a single-cycle pulse
      update_r <= 1'b0;
      case (state_r)
        config_net_pkg::node_idle: begin
          // falling line marks the start bit
          if (cfg_bit_i == `CONFIG_START_BIT) begin
            state_r <= config_net_pkg::node_id;
            cnt_r   <= '0;
          end
        end

        config_net_pkg::node_id: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_w'(`CONFIG_ID_BITS - 1)) begin
            // last id bit, decide whether this packet is ours
            state_r <= config_net_pkg::node_data;
            cnt_r   <= '0;
          end
        end

        config_net_pkg::node_data: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_w'(`CONFIG_DATA_BITS - 1)) begin
            state_r <= config_net_pkg::node_stop;
            cnt_r   <= '0;
            // commit only when the address matched
            if (match_r) begin
              data_r   <= shift_next;
              update_r <= 1'b1;
            end
          end
        end

        config_net_pkg::node_stop: begin
          // hold until line is high again, guards against a stuck-low line
          if (cfg_bit_i == `CONFIG_STOP_BIT) begin
            state_r <= config_net_pkg::node_idle;
          end
        end

        default: begin
          state_r <= config_net_pkg::node_idle;
        end
      endcase
    end
  end

  // field collector and match flag
  always_ff @(posedge clk_i) begin
    if (state_r == config_net_pkg::node_id ||
        state_r == config_net_pkg::node_data) begin
      shift_r <= shift_next;
    end
    // compare on the last id bit
    if (state_r == config_net_pkg::node_id &&
        cnt_r == cnt_w'(`CONFIG_ID_BITS - 1)) begin
      match_r <= (id_next == node_id_p);
    end
  end

  assign data_o   = data_r;
  assign update_o = update_r;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the config_net testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f config_net.f \
  --top-module config_net_tb \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vconfig_net_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# result is taken from the testbench output only
if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== src/config_net_top.sv ====
`timescale 1ns/1ns
`include "config_net_consts.svh"

module config_net_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         load_i,
  input  config_net_pkg::config_id_t   id_i,
  input  config_net_pkg::config_data_t data_i,
  output logic                         busy_o,
  output config_net_pkg::config_data_t node0_data_o,
  output logic                         node0_update_o,
  output config_net_pkg::config_data_t node1_data_o,
  output logic                         node1_update_o
);

  // line straight out of the producer
  logic cfg_bit;
  // same line after the relay delay
  logic cfg_relayed;

  // serial source, reset packet then one packet per load
  config_vector config_vector_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .load_i    (load_i),
    .id_i      (id_i),
    .data_i    (data_i),
    .cfg_bit_o (cfg_bit),
    .busy_o    (busy_o)
  );

  // wire delay model toward the far nodes
  config_relay config_relay_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_bit_i (cfg_bit),
    .cfg_bit_o (cfg_relayed)
  );

  // first consumer, also target of the reset packet
  config_node #(
    .node_id_p (`CONFIG_NODE0_ID)
  ) config_node0_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_bit_i (cfg_relayed),
    .data_o    (node0_data_o),
    .update_o  (node0_update_o)
  );

  // second consumer on the same relayed line
  config_node #(
    .node_id_p (`CONFIG_NODE1_ID)
  ) config_node1_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cfg_bit_i (cfg_relayed),
    .data_o    (node1_data_o),
    .update_o  (node1_update_o)
  );

endmodule

// ==== src/config_relay.sv ====
`timescale 1ns/1ns
`include "config_net_consts.svh"

module config_relay (
  input  logic clk_i,
  input  logic reset_i,
  input  logic cfg_bit_i,
  output logic cfg_bit_o
);

  // depth of the line delay
  localparam int stages_lp = `CONFIG_RELAY_STAGES;

  // stage 0 is nearest the producer
  logic [stages_lp-1:0] stage_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // whole chain reads as an idle line
      stage_r <= {stages_lp{`CONFIG_IDLE_BIT}};
    end else begin
      stage_r[0] <= cfg_bit_i;
      // each later stage follows the one before it
      for (int i = 1; i < stages_lp; i++) begin
        stage_r[i] <= stage_r[i-1];
      end
    end
  end

  // far end of the chain feeds the nodes
  assign cfg_bit_o = stage_r[stages_lp-1];

endmodule

// ==== src/config_vector.sv ====
`timescale 1ns/1ns
`include "config_net_consts.svh"

module config_vector (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       load_i,
  input  config_net_pkg::config_id_t   id_i,
  input  config_net_pkg::config_data_t data_i,
  output logic                       cfg_bit_o,
  output logic                       busy_o
);

  // enough range to count all packet bits plus the final value
  localparam int cnt_w = $clog2(`CONFIG_PACKET_BITS + 1);

  config_net_pkg::config_packet_t packet_r;
  logic [cnt_w-1:0]               cnt_r;
  logic                           bit_r;
  logic                           busy_r;

  // wrap id and data with start and stop bits, lsb leaves first
  function automatic config_net_pkg::config_packet_t frame_packet(
    input config_net_pkg::config_id_t   id,
    input config_net_pkg::config_data_t data
  );
    frame_packet = {`CONFIG_STOP_BIT, data, id, `CONFIG_START_BIT};
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // preload the power-on packet, sent as soon as reset drops
      packet_r <= frame_packet(`CONFIG_RESET_ID, `CONFIG_RESET_DATA);
      cnt_r    <= '0;
      busy_r   <= 1'b1;
      bit_r    <= `CONFIG_IDLE_BIT;
    end else if (busy_r) begin
      if (cnt_r == cnt_w'(`CONFIG_PACKET_BITS)) begin
        // stop bit was shown last cycle, release the line
        busy_r <= 1'b0;
        bit_r  <= `CONFIG_IDLE_BIT;
      end else begin
        // present the lowest bit and shift in idle level from the top
        bit_r    <= packet_r[0];
        packet_r <= {`CONFIG_IDLE_BIT, packet_r[`CONFIG_PACKET_BITS-1:1]};
        cnt_r    <= cnt_r + 1'b1;
      end
    end else if (load_i) begin
      // new packet, start bit goes out on the next edge
      packet_r <= frame_packet(id_i, data_i);
      cnt_r    <= '0;
      busy_r   <= 1'b1;
      bit_r    <= `CONFIG_IDLE_BIT;
    end
    // load_i while busy is dropped, no queue
  end

  assign cfg_bit_o = bit_r;
  assign busy_o    = busy_r;

endmodule

// ==== test/config_net_tb.sv ====
`timescale 1ns/1ns
`include "config_net_consts.svh"

module config_net_tb;

  // 40 ns clock period
  localparam int half_period_lp  = 20;
  localparam int period_lp       = 2 * half_period_lp;
  localparam int reset_cycles_lp = 8;
  // load-to-update latency plus some slack
  localparam int window_lp = `CONFIG_PACKET_BITS + `CONFIG_RELAY_STAGES + 4;
  // second load lands in the middle of the packet
  localparam int reload_at_lp   = 10;
  localparam int fixed_rows_lp  = 8;
  localparam int random_rows_lp = 6;
  localparam int rows_lp        = fixed_rows_lp + random_rows_lp;
  // two extra slots cover reset and the power-on packet
  localparam int watchdog_ns_lp =
    (rows_lp + 2) * (`CONFIG_PACKET_BITS + `CONFIG_RELAY_STAGES + 8) * period_lp;

  logic                         clk_i;
  logic                         reset_i;
  logic                         load_i;
  config_net_pkg::config_id_t   id_i;
  config_net_pkg::config_data_t data_i;
  logic                         busy_o;
  config_net_pkg::config_data_t node0_data_o;
  logic                         node0_update_o;
  config_net_pkg::config_data_t node1_data_o;
  logic                         node1_update_o;

  // stimulus table, one packet per row
  config_net_pkg::config_id_t   row_id     [rows_lp];
  config_net_pkg::config_data_t row_data   [rows_lp];
  // row gets a second load while the packet is still going out
  bit                           row_reload [rows_lp];

  // reference model of both node registers
  config_net_pkg::config_data_t model_data0;
  config_net_pkg::config_data_t model_data1;
  int                           model_pulses;
  int                           seen_pulses;
  int                           errors;
  int                           seed;

  config_net_top config_net_top_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .load_i         (load_i),
    .id_i           (id_i),
    .data_i         (data_i),
    .busy_o         (busy_o),
    .node0_data_o   (node0_data_o),
    .node0_update_o (node0_update_o),
    .node1_data_o   (node1_data_o),
    .node1_update_o (node1_update_o)
  );

  always #(half_period_lp) clk_i = ~clk_i;

  // run limit sized from the number of rows
  initial begin
    #(watchdog_ns_lp);
    $display("watchdog expired after %0d ns before the rows finished", watchdog_ns_lp);
    $display("tests failed");
    $finish;
  end

  // tally update pulses over the whole run, gaps between windows included
  always @(negedge clk_i) begin
    if (node0_update_o) begin
      seen_pulses++;
    end
    if (node1_update_o) begin
      seen_pulses++;
    end
  end

  task automatic set_row(input int idx, input config_net_pkg::config_id_t id,
                         input config_net_pkg::config_data_t data, input bit reload);
    row_id[idx]     = id;
    row_data[idx]   = data;
    row_reload[idx] = reload;
  endtask

  task automatic fill_table();
    int rnd;
    // addressed writes, unknown ids, then loads while busy
    set_row(0, `CONFIG_NODE1_ID, 16'h1234, 1'b0);
    set_row(1, `CONFIG_NODE0_ID, 16'h5a5a, 1'b0);
    set_row(2, 8'h77, 16'hdead, 1'b0);
    set_row(3, 8'h00, 16'hffff, 1'b0);
    set_row(4, `CONFIG_NODE0_ID, 16'hc3c3, 1'b1);
    set_row(5, `CONFIG_NODE1_ID, 16'h0001, 1'b1);
    set_row(6, `CONFIG_NODE0_ID, 16'h8000, 1'b0);
    set_row(7, `CONFIG_NODE1_ID, 16'h7ffe, 1'b0);
    // random payloads, targets alternate for back-to-back writes
    for (int i = fixed_rows_lp; i < rows_lp; i++) begin
      rnd = $random(seed);
      if (i % 2 == 0) begin
        set_row(i, `CONFIG_NODE0_ID, rnd[15:0], 1'b0);
      end else begin
        set_row(i, `CONFIG_NODE1_ID, rnd[15:0], 1'b0);
      end
    end
  endtask

  task automatic wait_not_busy();
    while (busy_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic pulse_load(input config_net_pkg::config_id_t id,
                            input config_net_pkg::config_data_t data);
    id_i   = id;
    data_i = data;
    load_i = 1'b1;
    @(negedge clk_i);
    load_i = 1'b0;
    // producer should have taken the packet
    assert (busy_o == 1'b1) else begin
      errors++;
      $display("mismatch busy_o: got %h expected %h", busy_o, 1'b1);
    end
  endtask

  // count update pulses and busy falls, optionally firing a stray load
  task automatic watch_window(input bit reload, input config_net_pkg::config_id_t stray_id,
                              input config_net_pkg::config_data_t stray_data,
                              output int pulses0, output int pulses1, output int busy_falls);
    logic busy_prev;
    pulses0    = 0;
    pulses1    = 0;
    busy_falls = 0;
    busy_prev  = busy_o;
    for (int c = 0; c < window_lp; c++) begin
      if (reload && c == reload_at_lp) begin
        id_i   = stray_id;
        data_i = stray_data;
        load_i = 1'b1;
      end else begin
        load_i = 1'b0;
      end
      @(negedge clk_i);
      // each pulse is one cycle wide so one falling edge sees it
      if (node0_update_o) begin
        pulses0++;
      end
      if (node1_update_o) begin
        pulses1++;
      end
      if (busy_prev && !busy_o) begin
        busy_falls++;
      end
      busy_prev = busy_o;
    end
    load_i = 1'b0;
  endtask

  task automatic check_outcome(input string what, input config_net_pkg::config_id_t id,
                               input config_net_pkg::config_data_t data,
                               input int pulses0, input int pulses1, input int busy_falls);
    int exp0;
    int exp1;
    // a node takes the packet only on an exact id match
    exp0 = (id == `CONFIG_NODE0_ID) ? 1 : 0;
    exp1 = (id == `CONFIG_NODE1_ID) ? 1 : 0;
    if (exp0 == 1) begin
      model_data0 = data;
    end
    if (exp1 == 1) begin
      model_data1 = data;
    end
    model_pulses += exp0 + exp1;
    assert (pulses0 == exp0) else begin
      errors++;
      $display("%s: node 0 gave %0d update pulses instead of %0d", what, pulses0, exp0);
    end
    assert (pulses1 == exp1) else begin
      errors++;
      $display("%s: node 1 gave %0d update pulses instead of %0d", what, pulses1, exp1);
    end
    assert (busy_falls == 1) else begin
      errors++;
      $display("%s: busy fell %0d times during the packet instead of once", what, busy_falls);
    end
    assert (busy_o == 1'b0) else begin
      errors++;
      $display("mismatch busy_o: got %h expected %h", busy_o, 1'b0);
    end
    assert (node0_data_o == model_data0) else begin
      errors++;
      $display("mismatch node0_data_o: got %h expected %h", node0_data_o, model_data0);
    end
    assert (node1_data_o == model_data1) else begin
      errors++;
      $display("mismatch node1_data_o: got %h expected %h", node1_data_o, model_data1);
    end
  endtask

  initial begin
    int                         p0;
    int                         p1;
    int                         falls;
    config_net_pkg::config_id_t stray_id;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    load_i       = 1'b0;
    id_i         = '0;
    data_i       = '0;
    errors       = 0;
    model_data0  = '0;
    model_data1  = '0;
    model_pulses = 0;
    seen_pulses  = 0;
    seed         = 32'hbcfc_9da0;
    fill_table();
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;
    // power-on packet goes out with no load
    watch_window(1'b0, '0, '0, p0, p1, falls);
    check_outcome("reset packet", `CONFIG_RESET_ID, `CONFIG_RESET_DATA, p0, p1, falls);
    for (int r = 0; r < rows_lp; r++) begin
      wait_not_busy();
      pulse_load(row_id[r], row_data[r]);
      // stray packet would hit the other node with inverted data
      stray_id = (row_id[r] == `CONFIG_NODE0_ID) ? `CONFIG_NODE1_ID : `CONFIG_NODE0_ID;
      watch_window(row_reload[r], stray_id, ~row_data[r], p0, p1, falls);
      check_outcome($sformatf("row %0d", r), row_id[r], row_data[r], p0, p1, falls);
    end
    // step off the falling edge so the pulse tally is settled
    @(posedge clk_i);
    assert (seen_pulses == model_pulses) else begin
      errors++;
      $display("saw %0d update pulses in total where %0d were expected",
               seen_pulses, model_pulses);
    end
    $display("%0d errors over %0d rows and the reset packet", errors, rows_lp);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
